/* logic/qdr_arbiter.sv */
`timescale 1ns/1ps
`include "qdr_defs.svh"

module qdr_arbiter (
  input  logic               qdr_clk,
  input  logic               qdr_rst,
  input  qdr_pkg::qdr_addr_t slave_addr,
  input  logic               slave_wr_strb,
  input  logic               slave_rd_strb,
  input  qdr_pkg::qdr_data_t slave_wr_data,
  input  qdr_pkg::qdr_be_t   slave_wr_be,
  input  logic               backdoor_req,
  input  logic               backdoor_r,
  input  logic               backdoor_w,
  input  qdr_pkg::qdr_addr_t backdoor_addr,
  input  qdr_pkg::qdr_data_t backdoor_d,
  input  qdr_pkg::qdr_be_t   backdoor_be,
  output logic               slave_ack,
  output logic               backdoor_ack,
  qdr_req_if.arb             bank_req [`QDR_NUM_BANKS]
);
  import qdr_pkg::*;

  arb_state_t                arb_state;
  logic                      slave_pending;
  logic                      slave_fields;
  logic                      sel_wr;
  logic                      sel_rd;
  qdr_addr_t                 sel_addr;
  qdr_data_t                 sel_data;
  qdr_be_t                   sel_be;
  rd_src_t                   sel_src;
  logic [`QDR_BANK_BITS-1:0] bank_sel;

  assign slave_pending = slave_wr_strb || slave_rd_strb;

  always_ff @(posedge qdr_clk) begin
    if (qdr_rst) begin
      arb_state <= SLAVE;
    end else begin
      case (arb_state)
        SLAVE: begin
          // Let a pending fabric strobe finish first
          if (backdoor_req) begin
            arb_state <= slave_pending ? SLAVE_WAIT : BACKDOOR;
          end
        end
        SLAVE_WAIT: begin
          arb_state <= BACKDOOR;
        end
        BACKDOOR: begin
          arb_state <= BACKDOOR_WAIT;   // Single slot for host
        end
        BACKDOOR_WAIT: begin
          arb_state <= SLAVE;
        end
        default: begin
          arb_state <= SLAVE;
        end
      endcase
    end
  end

  assign slave_ack    = arb_state == SLAVE;
  assign backdoor_ack = arb_state == BACKDOOR;

  // Slave write fields stay selected through SLAVE_WAIT
  assign slave_fields = (arb_state == SLAVE) || (arb_state == SLAVE_WAIT);

  assign sel_wr   = (slave_wr_strb && slave_ack) || (backdoor_w && backdoor_ack);
  assign sel_rd   = (slave_rd_strb && slave_ack) || (backdoor_r && backdoor_ack);
  assign sel_addr = slave_ack ? slave_addr : backdoor_addr;
  assign sel_data = slave_fields ? slave_wr_data : backdoor_d;
  assign sel_be   = slave_fields ? slave_wr_be : backdoor_be;
  assign sel_src  = backdoor_ack ? SRC_BACKDOOR : SRC_SLAVE;
  assign bank_sel = sel_addr[`QDR_BANK_BITS-1:0];     // Low bits pick the bank

  for (genvar b = 0; b < `QDR_NUM_BANKS; b++) begin : g_bank_drv
    localparam logic [`QDR_BANK_BITS-1:0] bank_id = b;
    logic hit;

    assign hit = bank_sel == bank_id;

    assign bank_req[b].wr_strb = sel_wr && hit;
    assign bank_req[b].rd_strb = sel_rd && hit;
    assign bank_req[b].addr    = sel_addr[`QDR_AWIDTH-1:`QDR_BANK_BITS];
    assign bank_req[b].wr_data = sel_data;
    assign bank_req[b].wr_be   = sel_be;
    assign bank_req[b].src     = sel_src;
  end

  a_state_legal: assert property (@(posedge qdr_clk) disable iff (qdr_rst)
    !$isunknown(arb_state) &&
    (arb_state inside {SLAVE, SLAVE_WAIT, BACKDOOR, BACKDOOR_WAIT}))
    else $error("arbiter state illegal");

  // Host never holds the path two cycles in a row
  a_bd_one_slot: assert property (@(posedge qdr_clk) disable iff (qdr_rst)
    backdoor_ack |=> !backdoor_ack)
    else $error("backdoor_ack held two cycles");

endmodule

/* logic/qdr_bank.sv */
`timescale 1ns/1ps
`include "qdr_defs.svh"

module qdr_bank (
  input  logic    qdr_clk,
  input  logic    qdr_rst,
  qdr_req_if.bank req
);
  import qdr_pkg::*;

  localparam int depth  = 1 << (`QDR_AWIDTH - `QDR_BANK_BITS);
  localparam int lane_w = `QDR_DWIDTH / `QDR_BEWIDTH;

  qdr_data_t               mem [depth];
  logic [`QDR_LATENCY-1:0] vld_pipe;
  rd_src_t                 src_pipe [`QDR_LATENCY];
  qdr_data_t               data_pipe [`QDR_LATENCY];

  // Byte-lane write
  always_ff @(posedge qdr_clk) begin
    if (req.wr_strb) begin
      for (int i = 0; i < `QDR_BEWIDTH; i++) begin
        if (req.wr_be[i]) begin
          mem[req.addr][i*lane_w +: lane_w] <= req.wr_data[i*lane_w +: lane_w];
        end
      end
    end
  end

  // Valid shift chain
  always_ff @(posedge qdr_clk) begin
    if (qdr_rst) begin
      vld_pipe <= '0;
    end else begin
      vld_pipe <= {vld_pipe[`QDR_LATENCY-2:0], req.rd_strb};
    end
  end

  // Tag and data follow the valid bits
  always_ff @(posedge qdr_clk) begin
    src_pipe[0]  <= req.src;
    data_pipe[0] <= mem[req.addr];
    for (int i = 1; i < `QDR_LATENCY; i++) begin
      src_pipe[i]  <= src_pipe[i-1];
      data_pipe[i] <= data_pipe[i-1];
    end
  end

  assign req.rd_dvld = vld_pipe[`QDR_LATENCY-1];
  assign req.rd_data = data_pipe[`QDR_LATENCY-1];
  assign req.rd_src  = src_pipe[`QDR_LATENCY-1];

  a_no_rw_clash: assert property (@(posedge qdr_clk) disable iff (qdr_rst)
    !(req.wr_strb && req.rd_strb))
    else $error("bank saw read and write strobe together");

endmodule

/* logic/qdr_defs.svh */
`ifndef QDR_DEFS_SVH
`define QDR_DEFS_SVH

// Word address, bank bits taken from the low end
`define QDR_AWIDTH    10
`define QDR_DWIDTH    36
`define QDR_BEWIDTH   4     // 9 bits per lane

`define QDR_NUM_BANKS 4
`define QDR_BANK_BITS 2

// Cycles from read strobe to valid data
`define QDR_LATENCY   10

`endif

/* logic/qdr_pkg.sv */
`include "qdr_defs.svh"

package qdr_pkg;

  // Arbiter grant states
  typedef enum logic [1:0] {
    SLAVE,
    SLAVE_WAIT,
    BACKDOOR,
    BACKDOOR_WAIT
  } arb_state_t;

  // Owner of a read in flight
  typedef enum logic {
    SRC_SLAVE,
    SRC_BACKDOOR
  } rd_src_t;

  typedef logic [`QDR_AWIDTH-1:0]  qdr_addr_t;
  typedef logic [`QDR_DWIDTH-1:0]  qdr_data_t;
  typedef logic [`QDR_BEWIDTH-1:0] qdr_be_t;

endpackage

/* logic/qdr_read_merge.sv */
`timescale 1ns/1ps
`include "qdr_defs.svh"

module qdr_read_merge (
  input  logic               qdr_clk,
  input  logic               qdr_rst,
  qdr_req_if.merge           bank_ret [`QDR_NUM_BANKS],
  output qdr_pkg::qdr_data_t slave_rd_data,
  output logic               slave_rd_dvld,
  output qdr_pkg::qdr_data_t backdoor_q,
  output logic               backdoor_qvld
);
  import qdr_pkg::*;

  logic [`QDR_NUM_BANKS-1:0] ret_vld;
  logic [`QDR_NUM_BANKS-1:0] ret_bd;
  qdr_data_t                 ret_data [`QDR_NUM_BANKS];
  qdr_data_t                 mux_data;
  logic                      mux_bd;

  for (genvar b = 0; b < `QDR_NUM_BANKS; b++) begin : g_collect
    assign ret_vld[b]  = bank_ret[b].rd_dvld;
    assign ret_bd[b]   = bank_ret[b].rd_src == SRC_BACKDOOR;
    assign ret_data[b] = bank_ret[b].rd_data;
  end

  // AND-OR select, only one bank returns per cycle
  always_comb begin
    mux_data = '0;
    mux_bd   = 1'b0;
    for (int b = 0; b < `QDR_NUM_BANKS; b++) begin
      mux_data = mux_data | (ret_data[b] & {`QDR_DWIDTH{ret_vld[b]}});
      mux_bd   = mux_bd | (ret_bd[b] & ret_vld[b]);
    end
  end

  assign slave_rd_data = mux_data;
  assign backdoor_q    = mux_data;
  assign slave_rd_dvld = (|ret_vld) && !mux_bd;
  assign backdoor_qvld = (|ret_vld) && mux_bd;

  a_one_return: assert property (@(posedge qdr_clk) disable iff (qdr_rst)
    $onehot0(ret_vld))
    else $error("more than one bank returned data");

endmodule

/* logic/qdr_req_if.sv */
`timescale 1ns/1ps
`include "qdr_defs.svh"

interface qdr_req_if;
  import qdr_pkg::*;

  // Request side
  logic                                  wr_strb;
  logic                                  rd_strb;
  logic [`QDR_AWIDTH-`QDR_BANK_BITS-1:0] addr;     // Index within the bank
  qdr_data_t                             wr_data;
  qdr_be_t                               wr_be;
  rd_src_t                               src;

  // Read return
  logic                                  rd_dvld;
  qdr_data_t                             rd_data;
  rd_src_t                               rd_src;

  modport arb (
    output wr_strb, rd_strb, addr, wr_data, wr_be, src
  );

  modport bank (
    input  wr_strb, rd_strb, addr, wr_data, wr_be, src,
    output rd_dvld, rd_data, rd_src
  );

  modport merge (
    input  rd_dvld, rd_data, rd_src
  );

endinterface

/* logic/qdr_sniffer_top.sv */
`timescale 1ns/1ps
`include "qdr_defs.svh"

module qdr_sniffer_top (
  input  logic               qdr_clk,
  input  logic               qdr_rst,

  // Fabric slave port
  input  qdr_pkg::qdr_addr_t slave_addr,
  input  logic               slave_wr_strb,
  input  qdr_pkg::qdr_data_t slave_wr_data,
  input  qdr_pkg::qdr_be_t   slave_wr_be,
  input  logic               slave_rd_strb,
  output logic               slave_ack,
  output qdr_pkg::qdr_data_t slave_rd_data,
  output logic               slave_rd_dvld,

  // Host backdoor port
  input  logic               backdoor_req,
  input  logic               backdoor_r,
  input  logic               backdoor_w,
  input  qdr_pkg::qdr_addr_t backdoor_addr,
  input  qdr_pkg::qdr_data_t backdoor_d,
  input  qdr_pkg::qdr_be_t   backdoor_be,
  output logic               backdoor_ack,
  output qdr_pkg::qdr_data_t backdoor_q,
  output logic               backdoor_qvld
);

  qdr_req_if bank_if [`QDR_NUM_BANKS] ();

  qdr_arbiter u_arbiter (
    .qdr_clk       (qdr_clk),
    .qdr_rst       (qdr_rst),
    .slave_addr    (slave_addr),
    .slave_wr_strb (slave_wr_strb),
    .slave_rd_strb (slave_rd_strb),
    .slave_wr_data (slave_wr_data),
    .slave_wr_be   (slave_wr_be),
    .backdoor_req  (backdoor_req),
    .backdoor_r    (backdoor_r),
    .backdoor_w    (backdoor_w),
    .backdoor_addr (backdoor_addr),
    .backdoor_d    (backdoor_d),
    .backdoor_be   (backdoor_be),
    .slave_ack     (slave_ack),
    .backdoor_ack  (backdoor_ack),
    .bank_req      (bank_if)
  );

  for (genvar b = 0; b < `QDR_NUM_BANKS; b++) begin : g_bank
    qdr_bank u_bank (
      .qdr_clk (qdr_clk),
      .qdr_rst (qdr_rst),
      .req     (bank_if[b])
    );
  end

  qdr_read_merge u_merge (
    .qdr_clk       (qdr_clk),
    .qdr_rst       (qdr_rst),
    .bank_ret      (bank_if),
    .slave_rd_data (slave_rd_data),
    .slave_rd_dvld (slave_rd_dvld),
    .backdoor_q    (backdoor_q),
    .backdoor_qvld (backdoor_qvld)
  );

endmodule

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f tb.f \
  --top-module tb_qdr_sniffer -o tb_qdr_sniffer
./obj_dir/tb_qdr_sniffer | tee sim.log

if grep -q "All tests passed!" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi

/* tb.f */
+incdir+logic
logic/qdr_pkg.sv
logic/qdr_req_if.sv
logic/qdr_arbiter.sv
logic/qdr_bank.sv
logic/qdr_read_merge.sv
logic/qdr_sniffer_top.sv
verif/tb_clk_gen.sv
verif/tb_qdr_sniffer.sv

/* verif/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen (
  output logic qdr_clk,
  output logic qdr_rst
);

  initial begin
    qdr_clk = 1'b0;
    forever #10 qdr_clk = ~qdr_clk;   // 20 ns period
  end

  // Three rising edges in reset, released on a falling edge
  initial begin
    qdr_rst = 1'b1;
    repeat (3) @(posedge qdr_clk);
    @(negedge qdr_clk);
    qdr_rst = 1'b0;
  end

endmodule

/* verif/tb_qdr_sniffer.sv */
`timescale 1ns/1ps
`include "qdr_defs.svh"

module tb_qdr_sniffer;
  import qdr_pkg::*;

  localparam int lane_w  = `QDR_DWIDTH / `QDR_BEWIDTH;
  localparam int ack_max = 8;

  logic      qdr_clk;
  logic      qdr_rst;
  qdr_addr_t slave_addr;
  logic      slave_wr_strb;
  qdr_data_t slave_wr_data;
  qdr_be_t   slave_wr_be;
  logic      slave_rd_strb;
  logic      slave_ack;
  qdr_data_t slave_rd_data;
  logic      slave_rd_dvld;
  logic      backdoor_req;
  logic      backdoor_r;
  logic      backdoor_w;
  qdr_addr_t backdoor_addr;
  qdr_data_t backdoor_d;
  qdr_be_t   backdoor_be;
  logic      backdoor_ack;
  qdr_data_t backdoor_q;
  logic      backdoor_qvld;

  int          cyc = 0;
  int          err_data = 0;
  int          err_ctrl = 0;
  int          err_other = 0;
  logic        aborted = 1'b0;
  logic [31:0] rng_state = 32'h3d74083b;
  qdr_data_t   ref_mem [1 << `QDR_AWIDTH];
  qdr_addr_t   addr_list [8];
  qdr_addr_t   bd_addr;
  int          exp_edge [$];   // Edge at which each read returns
  qdr_data_t   exp_data [$];
  rd_src_t     exp_src [$];
  int          ret_edge;
  qdr_data_t   ret_data;
  rd_src_t     ret_src;
  int          w;
  int          d;

  tb_clk_gen u_clk (.qdr_clk(qdr_clk), .qdr_rst(qdr_rst));

  qdr_sniffer_top uut (.*);

  always @(posedge qdr_clk) begin
    cyc <= cyc + 1;
  end

  task automatic check_data(input string name, input qdr_data_t exp, input qdr_data_t act);
    if (act !== exp) begin
      $display("FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
      err_data++;
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("FAILED at %0t: %s expected %b, got %b", $time, name, exp, act);
      err_ctrl++;
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
      $display("FAILED at %0t: %s expected %0d, got %0d", $time, name, exp, act);
      err_ctrl++;
    end
  endtask

  function automatic void timeout_hit(input string what);
    $display("Timed out at %0t while waiting for %s", $time, what);
    err_other++;
    aborted = 1'b1;
  endfunction

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic qdr_data_t rand_data();
    logic [31:0] hi;
    hi        = xorshift32(rng_state);
    rng_state = xorshift32(hi);
    return {hi[3:0], rng_state};
  endfunction

  function automatic qdr_addr_t rand_addr(input int bank);
    rng_state = xorshift32(rng_state);
    return {rng_state[`QDR_AWIDTH-1:`QDR_BANK_BITS], bank[`QDR_BANK_BITS-1:0]};
  endfunction

  // Only enabled 9-bit lanes take the new data
  function automatic void ref_write(input qdr_addr_t addr, input qdr_data_t data,
                                    input qdr_be_t be);
    for (int i = 0; i < `QDR_BEWIDTH; i++) begin
      if (be[i]) begin
        ref_mem[addr][i*lane_w +: lane_w] = data[i*lane_w +: lane_w];
      end
    end
  endfunction

  function automatic void push_read(input qdr_data_t data, input rd_src_t src);
    exp_edge.push_back(cyc + `QDR_LATENCY);
    exp_data.push_back(data);
    exp_src.push_back(src);
  endfunction

  // Every return must match the oldest outstanding read
  always @(negedge qdr_clk) begin
    if (!qdr_rst && (slave_rd_dvld || backdoor_qvld)) begin
      if (exp_edge.size() == 0) begin
        $display("Read data returned at %0t with no read outstanding", $time);
        err_other++;
      end else begin
        ret_edge = exp_edge.pop_front();
        ret_data = exp_data.pop_front();
        ret_src  = exp_src.pop_front();
        if (cyc + 1 != ret_edge) begin
          $display("Read returned at edge %0d instead of edge %0d", cyc + 1, ret_edge);
          err_other++;
        end
        check_bit("slave_rd_dvld", ret_src == SRC_SLAVE, slave_rd_dvld);
        check_bit("backdoor_qvld", ret_src == SRC_BACKDOOR, backdoor_qvld);
        if (ret_src == SRC_SLAVE) begin
          check_data("slave_rd_data", ret_data, slave_rd_data);
        end else begin
          check_data("backdoor_q", ret_data, backdoor_q);
        end
      end
    end
  end

  task automatic slave_access(input logic wr, input qdr_addr_t addr, input qdr_data_t data,
                              input qdr_be_t be, output int waits);
    waits = 0;
    if (aborted) return;
    slave_addr    = addr;
    slave_wr_strb = wr;
    slave_rd_strb = !wr;
    slave_wr_data = data;
    slave_wr_be   = be;
    while (!slave_ack && waits < ack_max) begin
      @(negedge qdr_clk);
      waits++;
    end
    if (!slave_ack) begin
      timeout_hit("slave_ack");
      return;
    end
    @(negedge qdr_clk);   // Taken on the edge just passed
    slave_wr_strb = 1'b0;
    slave_rd_strb = 1'b0;
    if (wr) begin
      ref_write(addr, data, be);
    end else begin
      push_read(ref_mem[addr], SRC_SLAVE);
    end
  endtask

  task automatic backdoor_access(input logic wr, input qdr_addr_t addr, input qdr_data_t data,
                                 input qdr_be_t be, output int delay);
    int raised_at;
    int n;
    delay = 0;
    if (aborted) return;
    raised_at     = cyc;
    n             = 0;
    backdoor_req  = 1'b1;
    backdoor_w    = wr;
    backdoor_r    = !wr;
    backdoor_addr = addr;
    backdoor_d    = data;
    backdoor_be   = be;
    while (!backdoor_ack && n < ack_max) begin
      @(negedge qdr_clk);
      n++;
    end
    if (!backdoor_ack) begin
      timeout_hit("backdoor_ack");
      return;
    end
    @(negedge qdr_clk);
    delay        = cyc - raised_at;
    backdoor_req = 1'b0;
    backdoor_w   = 1'b0;
    backdoor_r   = 1'b0;
    check_bit("backdoor_ack", 1'b0, backdoor_ack);   // Single-cycle grant
    if (wr) begin
      ref_write(addr, data, be);
    end else begin
      push_read(ref_mem[addr], SRC_BACKDOOR);
    end
  endtask

  task automatic wait_reads_done();
    int n;
    n = 0;
    if (aborted) return;
    while (exp_edge.size() != 0 && n < 4 * `QDR_LATENCY) begin
      @(negedge qdr_clk);
      n++;
    end
    if (exp_edge.size() != 0) begin
      timeout_hit("outstanding read data");
    end
  endtask

  task automatic reset_release();
    int n;
    n = 0;
    @(negedge qdr_clk);
    while (qdr_rst !== 1'b0 && n < 10) begin
      @(negedge qdr_clk);
      n++;
    end
    if (qdr_rst !== 1'b0) begin
      timeout_hit("reset release");
    end
    @(negedge qdr_clk);
  endtask

  task automatic reset_state_check();
    check_bit("slave_ack", 1'b1, slave_ack);
    check_bit("backdoor_ack", 1'b0, backdoor_ack);
    check_bit("slave_rd_dvld", 1'b0, slave_rd_dvld);
    check_bit("backdoor_qvld", 1'b0, backdoor_qvld);
  endtask

  task automatic slave_write_readback();
    for (int i = 0; i < 8; i++) begin
      addr_list[i] = rand_addr(i % `QDR_NUM_BANKS);
      slave_access(1'b1, addr_list[i], rand_data(), '1, w);
    end
    for (int i = 0; i < 8; i++) begin
      slave_access(1'b0, addr_list[i], '0, '0, w);
    end
    wait_reads_done();
  endtask

  task automatic byte_lane_writes();
    qdr_be_t   masks [4] = '{4'b0001, 4'b0110, 4'b1000, 4'b0101};
    qdr_addr_t addr;
    addr = rand_addr(1);
    slave_access(1'b1, addr, rand_data(), '1, w);
    for (int i = 0; i < 4; i++) begin
      slave_access(1'b1, addr, rand_data(), masks[i], w);
      slave_access(1'b0, addr, '0, '0, w);   // Read on the very next edge
    end
    wait_reads_done();
  endtask

  task automatic backdoor_while_idle();
    bd_addr = rand_addr(2);
    repeat (2) @(negedge qdr_clk);
    backdoor_access(1'b1, bd_addr, rand_data(), '1, d);
    check_count("backdoor_ack delay", 2, d);
    repeat (2) @(negedge qdr_clk);
    backdoor_access(1'b0, bd_addr, '0, '0, d);
    check_count("backdoor_ack delay", 2, d);
    wait_reads_done();
  endtask

  task automatic contention_with_slave();
    qdr_addr_t a_s1;
    qdr_addr_t a_s2;
    qdr_addr_t a_bd;
    qdr_data_t d_s1;
    qdr_data_t d_s2;
    qdr_data_t d_bd;
    int        w2;
    a_s1 = rand_addr(0);
    a_s2 = rand_addr(1);
    a_bd = rand_addr(3);
    d_s1 = rand_data();
    d_s2 = rand_data();
    d_bd = rand_data();
    repeat (2) @(negedge qdr_clk);
    fork
      begin
        slave_access(1'b1, a_s1, d_s1, '1, w);
        slave_access(1'b1, a_s2, d_s2, '1, w2);   // Held off by SLAVE_WAIT and host slot
      end
      backdoor_access(1'b1, a_bd, d_bd, '1, d);
    join
    check_count("slave_ack low cycles", 3, w2);
    check_count("backdoor_ack delay", 3, d);
    slave_access(1'b0, a_s1, '0, '0, w);
    slave_access(1'b0, a_s2, '0, '0, w);
    slave_access(1'b0, a_bd, '0, '0, w);
    wait_reads_done();
  endtask

  task automatic pipelined_reads();
    repeat (2) @(negedge qdr_clk);
    fork
      for (int i = 0; i < 8; i++) begin
        slave_access(1'b0, addr_list[7-i], '0, '0, w);
      end
      begin
        repeat (3) @(negedge qdr_clk);
        backdoor_access(1'b0, bd_addr, '0, '0, d);
      end
    join
    check_count("backdoor_ack delay", 3, d);
    wait_reads_done();
  endtask

  initial begin
    slave_addr    = '0;
    slave_wr_strb = 1'b0;
    slave_rd_strb = 1'b0;
    slave_wr_data = '0;
    slave_wr_be   = '0;
    backdoor_req  = 1'b0;
    backdoor_r    = 1'b0;
    backdoor_w    = 1'b0;
    backdoor_addr = '0;
    backdoor_d    = '0;
    backdoor_be   = '0;
    reset_release();
    reset_state_check();
    slave_write_readback();
    byte_lane_writes();
    backdoor_while_idle();
    contention_with_slave();
    pipelined_reads();
    $display("Errors: %0d data, %0d control, %0d other", err_data, err_ctrl, err_other);
    if (err_data + err_ctrl + err_other == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule
